// ==== design/smem_pkg.sv ====
package smem_pkg;

	// ------------------------------------------------------------------------
	// field widths of one match interval and one read result
	// ------------------------------------------------------------------------
	localparam int COORD_W    = 33;
	localparam int INFO_W     = 14;
	localparam int INTERVAL_W = INFO_W + 3 * COORD_W;
	localparam int READ_NUM_W = 8;
	localparam int MEM_SIZE_W = 7;
	localparam int RET_W      = 32;

	// header fields sit at the bottom, rest of the half is zero
	localparam int HDR_PAD_W = INTERVAL_W - READ_NUM_W - MEM_SIZE_W - RET_W;

	// one suffix-array interval, info on top
	typedef struct packed {
		logic [INFO_W-1:0]  info;
		logic [COORD_W-1:0] x2;
		logic [COORD_W-1:0] x1;
		logic [COORD_W-1:0] x0;
	} interval_t;

	// per-read summary
	typedef struct packed {
		logic [MEM_SIZE_W-1:0] mem_size;
		logic [RET_W-1:0]      ret;
	} read_result_t;

	// header beat payload, same width as an interval
	typedef struct packed {
		logic [HDR_PAD_W-1:0]  pad;
		logic [READ_NUM_W-1:0] read_num;
		logic [MEM_SIZE_W-1:0] mem_size;
		logic [RET_W-1:0]      ret;
	} beat_hdr_t;

	// one output beat, two intervals wide
	typedef struct packed {
		interval_t hi;
		interval_t lo;
	} out_beat_t;

endpackage

// ==== design/buf_ctrl_pkg.sv ====
package buf_ctrl_pkg;

	localparam int SLOT_W = 7;

	// ------------------------------------------------------------------------
	// output packer FSM
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		REQUEST = 3'd1,
		HEADER  = 3'd2,
		DATA    = 3'd3,
		GAP     = 3'd4,
		FINISH  = 3'd5
	} pack_state_e;

	// ------------------------------------------------------------------------
	// write strobes
	// ------------------------------------------------------------------------

	// interval write; toward a lane, read_num holds the local index
	typedef struct packed {
		logic [smem_pkg::READ_NUM_W-1:0] read_num;
		logic [SLOT_W-1:0]               slot;
		smem_pkg::interval_t             data;
	} interval_wr_t;

	// count and return code for one read
	typedef struct packed {
		logic [smem_pkg::READ_NUM_W-1:0] read_num;
		smem_pkg::read_result_t          result;
	} result_wr_t;

endpackage

// ==== design/mem_lane.sv ====
`timescale 1ns/1ns

module mem_lane #(
	parameter int READS_PER_LANE = 4,
	parameter int SLOTS          = 8
) (
	input  logic                              clk,

	// write port, fed by the dispatcher
	input  logic                              wr_valid,
	input  buf_ctrl_pkg::interval_wr_t        wr,

	// two read ports share the read index
	input  logic [$clog2(READS_PER_LANE)-1:0] rd_index,
	input  logic [$clog2(SLOTS)-1:0]          rd_slot_a,
	input  logic [$clog2(SLOTS)-1:0]          rd_slot_b,
	output smem_pkg::interval_t               rd_data_a,
	output smem_pkg::interval_t               rd_data_b
);

	localparam int IDX_W  = $clog2(READS_PER_LANE);
	localparam int SLOT_W = $clog2(SLOTS);

	// interval store, one row of slots per local read
	smem_pkg::interval_t store [READS_PER_LANE][SLOTS];

	logic [IDX_W-1:0]  wr_index;
	logic [SLOT_W-1:0] wr_slot;

	// local index and slot, trimmed to the store size
	assign wr_index = wr.read_num[IDX_W-1:0];
	assign wr_slot  = wr.slot[SLOT_W-1:0];

	// ------------------------------------------------------------------------
	// write side
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_valid) begin
			store[wr_index][wr_slot] <= wr.data;
		end
	end

	// ------------------------------------------------------------------------
	// read side, registered
	// ------------------------------------------------------------------------

	// port a carries the even slot of a pair
	always_ff @(posedge clk) begin
		rd_data_a <= store[rd_index][rd_slot_a];
	end

	// port b carries the odd slot
	always_ff @(posedge clk) begin
		rd_data_b <= store[rd_index][rd_slot_b];
	end

endmodule

// ==== design/read_dispatch.sv ====
`timescale 1ns/1ns

module read_dispatch #(
	parameter int NUM_LANES      = 2,
	parameter int READS_PER_LANE = 4
) (
	input  logic                       clk,
	input  logic                       reset_n,

	input  logic                       interval_wr_valid,
	input  buf_ctrl_pkg::interval_wr_t interval_wr,
	input  logic                       result_wr_valid,
	input  buf_ctrl_pkg::result_wr_t   result_wr,
	input  logic [7:0]                 batch_size,

	// one write strobe per lane
	output logic [NUM_LANES-1:0]       lane_wr_valid,
	output buf_ctrl_pkg::interval_wr_t lane_wr [NUM_LANES],

	// result table lookup for the packer
	input  logic [7:0]                 res_index,
	output smem_pkg::read_result_t     res_data,
	output logic                       all_done
);

	localparam int LANE_W    = $clog2(NUM_LANES);
	localparam int MAX_READS = NUM_LANES * READS_PER_LANE;
	localparam int RD_W      = $clog2(MAX_READS);

	smem_pkg::read_result_t     res_table [MAX_READS];
	logic [LANE_W-1:0]          wr_lane;
	buf_ctrl_pkg::interval_wr_t local_wr;
	logic [7:0]                 done_cnt;

	// ------------------------------------------------------------------------
	// interval routing
	// ------------------------------------------------------------------------

	// lane from the low bits, local index from the rest
	assign wr_lane = interval_wr.read_num[LANE_W-1:0];

	always_comb begin
		local_wr          = interval_wr;
		local_wr.read_num = interval_wr.read_num >> LANE_W;
	end

	// payload only moves for the lane that owns the read
	always_ff @(posedge clk) begin
		for (int l = 0; l < NUM_LANES; l++) begin
			if (interval_wr_valid && wr_lane == LANE_W'(l)) begin
				lane_wr[l] <= local_wr;
			end
		end
	end

	// ------------------------------------------------------------------------
	// result table
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (result_wr_valid) begin
			res_table[result_wr.read_num[RD_W-1:0]] <= result_wr.result;
		end
	end

	assign res_data = res_table[res_index[RD_W-1:0]];

	// strobes and batch completion
	always_ff @(posedge clk) begin
		if (reset_n) begin
			lane_wr_valid <= '0;
			done_cnt      <= '0;
			all_done      <= 1'b0;
		end else begin
			for (int l = 0; l < NUM_LANES; l++) begin
				lane_wr_valid[l] <= interval_wr_valid && wr_lane == LANE_W'(l);
			end
			if (result_wr_valid) begin
				done_cnt <= done_cnt + 8'd1;
			end
			// sticky until reset
			if (done_cnt == batch_size && batch_size != 8'd0) begin
				all_done <= 1'b1;
			end
		end
	end

endmodule

// ==== design/output_packer.sv ====
`timescale 1ns/1ns

module output_packer #(
	parameter int NUM_LANES      = 2,
	parameter int READS_PER_LANE = 4,
	parameter int SLOTS          = 8
) (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic [7:0]                        batch_size,
	input  logic                              all_done,
	input  logic                              output_permit,

	// result table lookup
	output logic [7:0]                        res_index,
	input  smem_pkg::read_result_t            res_data,

	// lane read ports, address shared by all lanes
	output logic [$clog2(READS_PER_LANE)-1:0] lane_rd_index,
	output logic [$clog2(SLOTS)-1:0]          lane_rd_slot_a,
	output logic [$clog2(SLOTS)-1:0]          lane_rd_slot_b,
	input  smem_pkg::interval_t               lane_rd_data_a [NUM_LANES],
	input  smem_pkg::interval_t               lane_rd_data_b [NUM_LANES],

	output logic                              output_request,
	output logic                              output_valid,
	output smem_pkg::out_beat_t               output_data,
	output logic                              output_finish
);

	localparam int LANE_W = $clog2(NUM_LANES);
	localparam int IDX_W  = $clog2(READS_PER_LANE);
	localparam int SLOT_W = $clog2(SLOTS);
	localparam int SIZE_W = smem_pkg::MEM_SIZE_W;

	buf_ctrl_pkg::pack_state_e state;
	logic [7:0]                rd_ptr;
	logic [SIZE_W-1:0]         cnt;
	logic [SIZE_W-1:0]         sent;
	logic                      stalled_q;
	logic [LANE_W-1:0]         lane_sel;
	smem_pkg::interval_t       hold_a;
	smem_pkg::interval_t       hold_b;
	smem_pkg::interval_t       src_a;
	smem_pkg::interval_t       src_b;
	smem_pkg::beat_hdr_t       hdr;
	logic                      odd_tail;
	logic                      last_beat;

	assign res_index     = rd_ptr;
	assign lane_sel      = rd_ptr[LANE_W-1:0];
	assign lane_rd_index = rd_ptr[LANE_W +: IDX_W];

	// ------------------------------------------------------------------------
	// lane data, with a skid copy across stalls
	// ------------------------------------------------------------------------

	// addresses run one pair ahead, so after a stall the lanes already show
	// the next pair; the copy taken in the first stalled cycle is the one due
	always_ff @(posedge clk) begin
		if (!stalled_q) begin
			hold_a <= lane_rd_data_a[lane_sel];
			hold_b <= lane_rd_data_b[lane_sel];
		end
	end

	assign src_a = stalled_q ? hold_a : lane_rd_data_a[lane_sel];
	assign src_b = stalled_q ? hold_b : lane_rd_data_b[lane_sel];

	// last pair of the read, hi half empty if odd
	assign odd_tail  = (sent + SIZE_W'(1) == cnt);
	assign last_beat = (sent + SIZE_W'(2) >= cnt);

	always_comb begin
		hdr          = '0;
		hdr.read_num = rd_ptr;
		hdr.mem_size = res_data.mem_size;
		hdr.ret      = res_data.ret;
	end

	// ------------------------------------------------------------------------
	// request / permit FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset_n) begin
			state          <= buf_ctrl_pkg::IDLE;
			output_request <= 1'b0;
			output_valid   <= 1'b0;
			output_finish  <= 1'b0;
			output_data    <= '0;
			rd_ptr         <= '0;
			cnt            <= '0;
			sent           <= '0;
			lane_rd_slot_a <= '0;
			lane_rd_slot_b <= SLOT_W'(1);
			stalled_q      <= 1'b0;
		end else begin
			stalled_q <= !output_permit;
			if (state == buf_ctrl_pkg::IDLE) begin
				// request goes out without waiting for permit
				if (all_done) begin
					output_request <= 1'b1;
					state          <= buf_ctrl_pkg::REQUEST;
				end
			end else if (output_permit) begin
				case (state)
					buf_ctrl_pkg::REQUEST: begin
						state <= buf_ctrl_pkg::HEADER;
					end
					buf_ctrl_pkg::HEADER: begin
						output_valid   <= 1'b1;
						output_data.lo <= smem_pkg::interval_t'(hdr);
						output_data.hi <= '0;
						cnt            <= res_data.mem_size;
						sent           <= '0;
						// slots 0/1 were addressed here, move on to 2/3
						lane_rd_slot_a <= lane_rd_slot_a + SLOT_W'(2);
						lane_rd_slot_b <= lane_rd_slot_b + SLOT_W'(2);
						if (res_data.mem_size == '0) begin
							state <= buf_ctrl_pkg::GAP;
						end else begin
							state <= buf_ctrl_pkg::DATA;
						end
					end
					buf_ctrl_pkg::DATA: begin
						output_valid   <= 1'b1;
						output_data.lo <= src_a;
						if (odd_tail) begin
							output_data.hi <= '0;
						end else begin
							output_data.hi <= src_b;
						end
						sent           <= sent + SIZE_W'(2);
						lane_rd_slot_a <= lane_rd_slot_a + SLOT_W'(2);
						lane_rd_slot_b <= lane_rd_slot_b + SLOT_W'(2);
						if (last_beat) begin
							state <= buf_ctrl_pkg::GAP;
						end
					end
					buf_ctrl_pkg::GAP: begin
						// idle beat, point at the next read's first pair
						output_valid   <= 1'b0;
						rd_ptr         <= rd_ptr + 8'd1;
						lane_rd_slot_a <= '0;
						lane_rd_slot_b <= SLOT_W'(1);
						if (rd_ptr + 8'd1 == batch_size) begin
							state <= buf_ctrl_pkg::FINISH;
						end else begin
							state <= buf_ctrl_pkg::HEADER;
						end
					end
					buf_ctrl_pkg::FINISH: begin
						output_valid   <= 1'b0;
						output_finish  <= 1'b1;
						output_request <= 1'b0;
					end
					default: begin
						state <= buf_ctrl_pkg::IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== design/mem_buffer_top.sv ====
`timescale 1ns/1ns

module mem_buffer_top #(
	parameter int NUM_LANES      = 2,
	parameter int READS_PER_LANE = 4,
	parameter int SLOTS          = 8
) (
	input  logic                       clk,
	input  logic                       reset_n,

	input  logic                       interval_wr_valid,
	input  buf_ctrl_pkg::interval_wr_t interval_wr,
	input  logic                       result_wr_valid,
	input  buf_ctrl_pkg::result_wr_t   result_wr,
	input  logic [7:0]                 batch_size,

	input  logic                       output_permit,
	output logic                       output_request,
	output logic                       output_valid,
	output smem_pkg::out_beat_t        output_data,
	output logic                       output_finish
);

	localparam int IDX_W  = $clog2(READS_PER_LANE);
	localparam int SLOT_W = $clog2(SLOTS);

	// dispatcher to lanes
	logic [NUM_LANES-1:0]       lane_wr_valid;
	buf_ctrl_pkg::interval_wr_t lane_wr [NUM_LANES];

	// packer to dispatcher and lanes
	logic [7:0]                 res_index;
	smem_pkg::read_result_t     res_data;
	logic                       all_done;
	logic [IDX_W-1:0]           lane_rd_index;
	logic [SLOT_W-1:0]          lane_rd_slot_a;
	logic [SLOT_W-1:0]          lane_rd_slot_b;
	smem_pkg::interval_t        lane_rd_data_a [NUM_LANES];
	smem_pkg::interval_t        lane_rd_data_b [NUM_LANES];

	read_dispatch #(
		.NUM_LANES      (NUM_LANES),
		.READS_PER_LANE (READS_PER_LANE)
	) read_dispatch_inst (
		.clk               (clk),
		.reset_n           (reset_n),
		.interval_wr_valid (interval_wr_valid),
		.interval_wr       (interval_wr),
		.result_wr_valid   (result_wr_valid),
		.result_wr         (result_wr),
		.batch_size        (batch_size),
		.lane_wr_valid     (lane_wr_valid),
		.lane_wr           (lane_wr),
		.res_index         (res_index),
		.res_data          (res_data),
		.all_done          (all_done)
	);

	// ------------------------------------------------------------------------
	// storage lanes
	// ------------------------------------------------------------------------
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		mem_lane #(
			.READS_PER_LANE (READS_PER_LANE),
			.SLOTS          (SLOTS)
		) mem_lane_inst (
			.clk       (clk),
			.wr_valid  (lane_wr_valid[g]),
			.wr        (lane_wr[g]),
			.rd_index  (lane_rd_index),
			.rd_slot_a (lane_rd_slot_a),
			.rd_slot_b (lane_rd_slot_b),
			.rd_data_a (lane_rd_data_a[g]),
			.rd_data_b (lane_rd_data_b[g])
		);
	end

	output_packer #(
		.NUM_LANES      (NUM_LANES),
		.READS_PER_LANE (READS_PER_LANE),
		.SLOTS          (SLOTS)
	) output_packer_inst (
		.clk            (clk),
		.reset_n        (reset_n),
		.batch_size     (batch_size),
		.all_done       (all_done),
		.output_permit  (output_permit),
		.res_index      (res_index),
		.res_data       (res_data),
		.lane_rd_index  (lane_rd_index),
		.lane_rd_slot_a (lane_rd_slot_a),
		.lane_rd_slot_b (lane_rd_slot_b),
		.lane_rd_data_a (lane_rd_data_a),
		.lane_rd_data_b (lane_rd_data_b),
		.output_request (output_request),
		.output_valid   (output_valid),
		.output_data    (output_data),
		.output_finish  (output_finish)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk,
	output logic reset_n
);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset is active high, released on a falling edge after 8 cycles
	initial begin
		reset_n = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_n <= 1'b0;
	end

endmodule

// ==== tb/tb_mem_buffer.sv ====
`timescale 1ns/1ns

module tb_mem_buffer;

	localparam int NUM_LANES      = 2;
	localparam int READS_PER_LANE = 4;
	localparam int SLOTS          = 8;
	localparam int NUM_READS      = NUM_LANES * READS_PER_LANE;

	logic                       clk;
	logic                       reset_n;
	logic                       interval_wr_valid;
	buf_ctrl_pkg::interval_wr_t interval_wr;
	logic                       result_wr_valid;
	buf_ctrl_pkg::result_wr_t   result_wr;
	logic [7:0]                 batch_size;
	logic                       output_permit;
	logic                       output_request;
	logic                       output_valid;
	smem_pkg::out_beat_t        output_data;
	logic                       output_finish;

	// ------------------------------------------------------------------------
	// stimulus table with one row per read, not in read order
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [7:0]  read_num;
		logic [6:0]  mem_size;
		logic [31:0] ret;
	} stim_row_t;

	stim_row_t stim [NUM_READS] = '{
		'{8'd5, 7'd2, 32'h0000_5005},
		'{8'd0, 7'd3, 32'h0000_0001},
		'{8'd3, 7'd1, 32'hffff_fff3},
		'{8'd1, 7'd0, 32'hdead_0001},
		'{8'd7, 7'd7, 32'h7777_0007},
		'{8'd2, 7'd8, 32'h8000_0002},
		'{8'd6, 7'd0, 32'h0000_0000},
		'{8'd4, 7'd5, 32'hc0de_0004}
	};

	smem_pkg::interval_t model [NUM_READS][SLOTS];
	int                  exp_size [NUM_READS];
	logic [31:0]         exp_ret [NUM_READS];
	int                  wr_q [$];

	// predicted output stream
	smem_pkg::out_beat_t exp_q [$];
	string               name_q [$];
	bit                  hdr_q [$];

	int                  value_errs = 0;
	int                  proto_errs = 0;
	int                  cycles = 0;
	int                  cycle_limit = 100000;
	int                  beats_seen = 0;
	logic                adv = 1'b0;
	logic                saw_gap = 1'b0;
	logic                finish_seen = 1'b0;
	logic                prev_valid = 1'b0;
	smem_pkg::out_beat_t prev_data = '0;

	tb_clock_gen tb_clock_gen_inst (
		.clk     (clk),
		.reset_n (reset_n)
	);

	mem_buffer_top #(
		.NUM_LANES      (NUM_LANES),
		.READS_PER_LANE (READS_PER_LANE),
		.SLOTS          (SLOTS)
	) mem_buffer_top_inst (
		.clk               (clk),
		.reset_n           (reset_n),
		.interval_wr_valid (interval_wr_valid),
		.interval_wr       (interval_wr),
		.result_wr_valid   (result_wr_valid),
		.result_wr         (result_wr),
		.batch_size        (batch_size),
		.output_permit     (output_permit),
		.output_request    (output_request),
		.output_valid      (output_valid),
		.output_data       (output_data),
		.output_finish     (output_finish)
	);

	// compare one transferred beat with the head of the prediction
	task check_beat();
		smem_pkg::out_beat_t exp_beat;
		string               name;
		bit                  is_hdr;
		assert (exp_q.size() != 0) else begin
			proto_errs++;
			$display("extra beat received after the expected stream ended");
		end
		if (exp_q.size() != 0) begin
			exp_beat = exp_q.pop_front();
			name     = name_q.pop_front();
			is_hdr   = hdr_q.pop_front();
			assert (output_data == exp_beat) else begin
				value_errs++;
				$display("[FAIL] %s expected %h actual %h", name, exp_beat, output_data);
			end
			if (is_hdr && beats_seen > 0) begin
				assert (saw_gap) else begin
					proto_errs++;
					$display("no idle cycle before %s", name);
				end
			end
			beats_seen++;
		end
		saw_gap = 1'b0;
	endtask

	// permit as seen by the DUT at the rising edge
	always @(posedge clk) begin
		adv <= output_permit;
	end

	// ------------------------------------------------------------------------
	// output monitor
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		if (!reset_n) begin
			if (!adv) begin
				assert (output_valid == prev_valid && output_data == prev_data) else begin
					proto_errs++;
					$display("output changed at an edge where permit was low");
				end
			end else if (output_valid) begin
				check_beat();
			end
			if (!output_valid) begin
				saw_gap = 1'b1;
			end
			// request must hold through the whole stream
			if (beats_seen > 0 && !output_finish) begin
				assert (output_request) else begin
					proto_errs++;
					$display("request dropped before the end of the stream");
				end
			end
			if (finish_seen) begin
				assert (output_finish && !output_valid) else begin
					proto_errs++;
					$display("finish dropped or valid rose after the end of the stream");
				end
			end else if (output_finish) begin
				assert (exp_q.size() == 0) else begin
					proto_errs++;
					$display("finish rose with %0d beats still missing", exp_q.size());
				end
				finish_seen = 1'b1;
			end
		end
		prev_valid = output_valid;
		prev_data  = output_data;
	end

	// run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			proto_errs++;
			$display("timeout: stream not complete after %0d cycles", cycle_limit);
			$display("errors: value %0d, protocol %0d", value_errs, proto_errs);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		logic [127:0]        rnd;
		int                  r;
		int                  j;
		int                  tmp;
		smem_pkg::beat_hdr_t hdr;
		smem_pkg::out_beat_t beat;

		void'($urandom(87));
		interval_wr_valid = 1'b0;
		interval_wr       = '0;
		result_wr_valid   = 1'b0;
		result_wr         = '0;
		batch_size        = 8'(NUM_READS);
		output_permit     = 1'b0;

		for (int i = 0; i < NUM_READS; i++) begin
			exp_size[stim[i].read_num] = int'(stim[i].mem_size);
			exp_ret[stim[i].read_num]  = stim[i].ret;
		end

		// random interval contents with one write per stored slot
		for (r = 0; r < NUM_READS; r++) begin
			for (int s = 0; s < exp_size[r]; s++) begin
				rnd         = {$urandom(), $urandom(), $urandom(), $urandom()};
				model[r][s] = rnd[112:0];
				wr_q.push_back(r * 16 + s);
			end
		end

		// shuffle the write order across reads
		for (int i = wr_q.size() - 1; i > 0; i--) begin
			j       = int'($urandom_range(i, 0));
			tmp     = wr_q[i];
			wr_q[i] = wr_q[j];
			wr_q[j] = tmp;
		end

		// header and then pairs of intervals for each read in ascending order
		for (r = 0; r < NUM_READS; r++) begin
			hdr          = '0;
			hdr.read_num = 8'(r);
			hdr.mem_size = 7'(exp_size[r]);
			hdr.ret      = exp_ret[r];
			beat.lo      = smem_pkg::interval_t'(hdr);
			beat.hi      = '0;
			exp_q.push_back(beat);
			name_q.push_back($sformatf("read %0d header", r));
			hdr_q.push_back(1'b1);
			for (int s = 0; s < exp_size[r]; s += 2) begin
				beat.lo = model[r][s];
				beat.hi = (s + 1 < exp_size[r]) ? model[r][s+1] : '0;
				exp_q.push_back(beat);
				name_q.push_back($sformatf("read %0d slots %0d/%0d", r, s, s + 1));
				hdr_q.push_back(1'b0);
			end
		end
		cycle_limit = 20 * exp_q.size() + wr_q.size() + 100;

		@(negedge clk);
		while (reset_n) begin
			@(negedge clk);
		end

		// ------------------------------------------------------------------------
		// interval writes followed by result strobes
		// ------------------------------------------------------------------------
		for (int i = 0; i < wr_q.size(); i++) begin
			assert (!output_request) else begin
				proto_errs++;
				$display("request high during interval writes");
			end
			interval_wr_valid    = 1'b1;
			interval_wr.read_num = 8'(wr_q[i] / 16);
			interval_wr.slot     = 7'(wr_q[i] % 16);
			interval_wr.data     = model[wr_q[i] / 16][wr_q[i] % 16];
			@(negedge clk);
		end
		interval_wr_valid = 1'b0;

		for (int i = 0; i < NUM_READS; i++) begin
			assert (!output_request) else begin
				proto_errs++;
				$display("request high before the last result strobe");
			end
			result_wr_valid          = 1'b1;
			result_wr.read_num       = stim[i].read_num;
			result_wr.result.mem_size = stim[i].mem_size;
			result_wr.result.ret     = stim[i].ret;
			@(negedge clk);
		end
		result_wr_valid = 1'b0;

		while (!output_request) begin
			@(negedge clk);
		end

		// drain with permit dropping now and then
		while (!output_finish) begin
			output_permit = ($urandom_range(3, 0) != 0);
			@(negedge clk);
		end
		repeat (10) begin
			output_permit = ($urandom_range(3, 0) != 0);
			@(negedge clk);
		end

		$display("errors: value %0d, protocol %0d", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
design/smem_pkg.sv
design/buf_ctrl_pkg.sv
design/mem_lane.sv
design/read_dispatch.sv
design/output_packer.sv
design/mem_buffer_top.sv
tb/tb_clock_gen.sv
tb/tb_mem_buffer.sv

// ==== Makefile ====
# Verilator build and run for the result buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_buffer
RTL_TOP   ?= mem_buffer_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) $(shell grep '^design/' $(FILELIST)) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
